// ==== rtl/mpc_xbar_params.svh ====
`ifndef MPC_XBAR_PARAMS_SVH
`define MPC_XBAR_PARAMS_SVH

// **************************************************
// crossbar geometry
// **************************************************
`define MPC_NUM_CH      3
`define MPC_NUM_BANK    4

`define MPC_ADDR_W      32
`define MPC_DATA_W      128

// bank select sits just above the 16-byte line offset
`define MPC_BANK_LSB    4

// **************************************************
// buffer depths
// **************************************************
`define MPC_WBUF_DEPTH  4    // write-buffer ids per bank
`define MPC_ROB_DEPTH   4    // reorder slots per channel

`endif

// ==== rtl/mpc_pkg.sv ====
`include "mpc_xbar_params.svh"

package mpc_pkg;

    // payload
    typedef logic [`MPC_ADDR_W-1:0] addr_t;
    typedef logic [`MPC_DATA_W-1:0] data_t;

    // routing tags
    typedef logic [$clog2(`MPC_NUM_BANK)-1:0] bank_id_t;
    typedef logic [$clog2(`MPC_NUM_CH)-1:0]   ch_id_t;

    // buffer indices, echoed back by the banks
    typedef logic [$clog2(`MPC_WBUF_DEPTH)-1:0] wbuf_id_t;
    typedef logic [$clog2(`MPC_ROB_DEPTH)-1:0]  rob_id_t;

endpackage

// ==== rtl/mpc_ifs.sv ====
`timescale 1ns/1ps

// request from a channel reorder buffer into the request crossbar
interface ch_req_if
    import mpc_pkg::*;
();
    logic    valid;
    logic    ready;
    logic    write;
    addr_t   addr;
    data_t   wdata;
    rob_id_t rob_id;    // reorder slot reserved for the response

    modport source (
        output valid, write, addr, wdata, rob_id,
        input  ready
    );

    modport target (
        input  valid, write, addr, wdata, rob_id,
        output ready
    );
endinterface

// arbitrated request heading for one bank, before the write-buffer id gate
interface bank_req_if
    import mpc_pkg::*;
();
    logic    valid;
    logic    ready;
    logic    write;
    addr_t   addr;
    data_t   wdata;
    ch_id_t  ch_id;
    rob_id_t rob_id;

    modport source (
        output valid, write, addr, wdata, ch_id, rob_id,
        input  ready
    );

    modport target (
        input  valid, write, addr, wdata, ch_id, rob_id,
        output ready
    );
endinterface

// ==== rtl/req_xbar.sv ====
`timescale 1ns/1ps
`include "mpc_xbar_params.svh"

module req_xbar
    import mpc_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    ch_req_if.target    ch_req   [`MPC_NUM_CH],
    bank_req_if.source  bank_req [`MPC_NUM_BANK]
);

    localparam int NUM_CH   = `MPC_NUM_CH;
    localparam int NUM_BANK = `MPC_NUM_BANK;

    logic [NUM_CH-1:0]   ch_valid;
    logic [NUM_CH-1:0]   ch_write;
    logic [NUM_CH-1:0]   ch_ready;
    addr_t               ch_addr   [NUM_CH];
    data_t               ch_wdata  [NUM_CH];
    rob_id_t             ch_rob_id [NUM_CH];
    bank_id_t            ch_bank   [NUM_CH];

    logic [NUM_BANK-1:0] gnt_any;
    logic [NUM_BANK-1:0] bank_ready;
    ch_id_t              gnt_ch    [NUM_BANK];
    ch_id_t              last_q    [NUM_BANK];    // last accepted winner per bank

    for (genvar c = 0; c < NUM_CH; c++) begin : g_ch
        assign ch_valid[c]  = ch_req[c].valid;
        assign ch_write[c]  = ch_req[c].write;
        assign ch_addr[c]   = ch_req[c].addr;
        assign ch_wdata[c]  = ch_req[c].wdata;
        assign ch_rob_id[c] = ch_req[c].rob_id;
        assign ch_bank[c]   = ch_req[c].addr[`MPC_BANK_LSB +: $bits(bank_id_t)];
        assign ch_req[c].ready = ch_ready[c];
    end

    // **************************************************
    // round-robin per bank
    // **************************************************
    always_comb begin
        int idx;
        for (int b = 0; b < NUM_BANK; b++) begin
            gnt_any[b] = 1'b0;
            gnt_ch[b]  = '0;
            // walk backwards so the channel right after the last winner wins
            for (int i = NUM_CH; i >= 1; i--) begin
                idx = (int'(last_q[b]) + i) % NUM_CH;
                if (ch_valid[idx] && ch_bank[idx] == bank_id_t'(b)) begin
                    gnt_any[b] = 1'b1;
                    gnt_ch[b]  = ch_id_t'(idx);
                end
            end
        end
    end

    always_comb begin
        ch_ready = '0;
        for (int b = 0; b < NUM_BANK; b++) begin
            if (gnt_any[b] && bank_ready[b])
                ch_ready[gnt_ch[b]] = 1'b1;
        end
    end

    for (genvar b = 0; b < NUM_BANK; b++) begin : g_bank
        assign bank_req[b].valid  = gnt_any[b];
        assign bank_req[b].write  = ch_write[gnt_ch[b]];
        assign bank_req[b].addr   = ch_addr[gnt_ch[b]];
        assign bank_req[b].wdata  = ch_wdata[gnt_ch[b]];
        assign bank_req[b].ch_id  = gnt_ch[b];
        assign bank_req[b].rob_id = ch_rob_id[gnt_ch[b]];
        assign bank_ready[b]      = bank_req[b].ready;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int b = 0; b < NUM_BANK; b++)
                last_q[b] <= ch_id_t'(NUM_CH - 1);    // channel 0 goes first
        end else begin
            for (int b = 0; b < NUM_BANK; b++) begin
                if (gnt_any[b] && bank_ready[b])
                    last_q[b] <= gnt_ch[b];    // a stalled grant keeps the pointer
            end
        end
    end

endmodule

// ==== rtl/wbuf_id_alloc.sv ====
`timescale 1ns/1ps
`include "mpc_xbar_params.svh"

module wbuf_id_alloc
    import mpc_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    bank_req_if.target  req_in,

    output logic        bank_req_valid,
    output logic        bank_req_write,
    output addr_t       bank_req_addr,
    output data_t       bank_req_wdata,
    output ch_id_t      bank_req_ch_id,
    output rob_id_t     bank_req_rob_id,
    output wbuf_id_t    bank_req_wbuf_id,
    input  logic        bank_req_ready,

    input  logic        free_valid,
    input  wbuf_id_t    free_id
);

    localparam int DEPTH = `MPC_WBUF_DEPTH;
    localparam int CNT_W = $clog2(DEPTH + 1);

    wbuf_id_t         free_list [DEPTH];
    wbuf_id_t         rd_ptr_q;
    wbuf_id_t         wr_ptr_q;
    logic [CNT_W-1:0] cnt_q;
    logic             empty;
    logic             id_ok;
    logic             pop;

    assign empty = (cnt_q == '0);
    assign id_ok = !req_in.write || !empty;    // reads pass without an id

    assign bank_req_valid   = req_in.valid && id_ok;
    assign req_in.ready     = bank_req_ready && id_ok;
    assign bank_req_write   = req_in.write;
    assign bank_req_addr    = req_in.addr;
    assign bank_req_wdata   = req_in.wdata;
    assign bank_req_ch_id   = req_in.ch_id;
    assign bank_req_rob_id  = req_in.rob_id;
    assign bank_req_wbuf_id = free_list[rd_ptr_q];

    assign pop = bank_req_valid && bank_req_ready && req_in.write;

    // **************************************************
    // free list fifo, full of ids out of reset
    // **************************************************
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++)
                free_list[i] <= wbuf_id_t'(i);
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= CNT_W'(DEPTH);
        end else begin
            if (pop)
                rd_ptr_q <= rd_ptr_q + wbuf_id_t'(1);
            if (free_valid) begin
                free_list[wr_ptr_q] <= free_id;    // usable next cycle
                wr_ptr_q            <= wr_ptr_q + wbuf_id_t'(1);
            end
            case ({free_valid, pop})
                2'b10:   cnt_q <= cnt_q + CNT_W'(1);
                2'b01:   cnt_q <= cnt_q - CNT_W'(1);
                default: cnt_q <= cnt_q;
            endcase
        end
    end

endmodule

// ==== rtl/chan_rob.sv ====
`timescale 1ns/1ps
`include "mpc_xbar_params.svh"

module chan_rob
    import mpc_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  logic       req_valid,
    input  logic       req_write,
    input  addr_t      req_addr,
    input  data_t      req_wdata,
    output logic       req_ready,
    ch_req_if.source   ch_req,

    input  logic       rsp_valid,
    input  rob_id_t    rsp_rob_id,
    input  data_t      rsp_data,

    output logic       ch_rsp_valid,
    output data_t      ch_rsp_data,
    input  logic       ch_rsp_ready
);

    localparam int DEPTH = `MPC_ROB_DEPTH;
    localparam int CNT_W = $clog2(DEPTH + 1);

    rob_id_t          head_q;
    rob_id_t          tail_q;
    logic [CNT_W-1:0] cnt_q;
    logic [DEPTH-1:0] present_q;    // response data landed in slot
    data_t            slot_data [DEPTH];

    logic             full;
    logic             alloc;
    logic             retire;

    assign full = (cnt_q == CNT_W'(DEPTH));

    // **************************************************
    // issue side, tail slot reserved on acceptance
    // **************************************************
    assign ch_req.valid  = req_valid && !full;
    assign ch_req.write  = req_write;
    assign ch_req.addr   = req_addr;
    assign ch_req.wdata  = req_wdata;
    assign ch_req.rob_id = tail_q;
    assign req_ready     = ch_req.ready && !full;

    assign alloc = ch_req.valid && ch_req.ready;

    // **************************************************
    // return side, in issue order
    // **************************************************
    assign ch_rsp_valid = (cnt_q != '0) && present_q[head_q];
    assign ch_rsp_data  = slot_data[head_q];
    assign retire       = ch_rsp_valid && ch_rsp_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_q    <= '0;
            tail_q    <= '0;
            cnt_q     <= '0;
            present_q <= '0;
        end else begin
            if (alloc)
                tail_q <= tail_q + rob_id_t'(1);
            if (retire) begin
                head_q            <= head_q + rob_id_t'(1);
                present_q[head_q] <= 1'b0;    // slot is free again
            end
            // never the head slot while it retires, that one is already present
            if (rsp_valid)
                present_q[rsp_rob_id] <= 1'b1;
            case ({alloc, retire})
                2'b10:   cnt_q <= cnt_q + CNT_W'(1);
                2'b01:   cnt_q <= cnt_q - CNT_W'(1);
                default: cnt_q <= cnt_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_valid)
            slot_data[rsp_rob_id] <= rsp_data;
    end

endmodule

// ==== rtl/rsp_xbar.sv ====
`timescale 1ns/1ps
`include "mpc_xbar_params.svh"

module rsp_xbar
    import mpc_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic [`MPC_NUM_BANK-1:0] bank_rsp_valid,
    input  data_t                    bank_rsp_data   [`MPC_NUM_BANK],
    input  ch_id_t                   bank_rsp_ch_id  [`MPC_NUM_BANK],
    input  rob_id_t                  bank_rsp_rob_id [`MPC_NUM_BANK],
    output logic [`MPC_NUM_BANK-1:0] bank_rsp_ready,

    output logic [`MPC_NUM_CH-1:0]   rsp_valid,
    output rob_id_t                  rsp_rob_id      [`MPC_NUM_CH],
    output data_t                    rsp_data        [`MPC_NUM_CH]
);

    localparam int NUM_CH   = `MPC_NUM_CH;
    localparam int NUM_BANK = `MPC_NUM_BANK;

    logic [NUM_CH-1:0] gnt_any;
    bank_id_t          gnt_bank [NUM_CH];
    bank_id_t          last_q   [NUM_CH];

    // one round-robin per channel over the banks that target it
    always_comb begin
        int idx;
        for (int c = 0; c < NUM_CH; c++) begin
            gnt_any[c]  = 1'b0;
            gnt_bank[c] = '0;
            for (int i = NUM_BANK; i >= 1; i--) begin
                idx = (int'(last_q[c]) + i) % NUM_BANK;
                if (bank_rsp_valid[idx] && bank_rsp_ch_id[idx] == ch_id_t'(c)) begin
                    gnt_any[c]  = 1'b1;
                    gnt_bank[c] = bank_id_t'(idx);
                end
            end
        end
    end

    always_comb begin
        bank_rsp_ready = '0;
        for (int c = 0; c < NUM_CH; c++) begin
            rsp_valid[c]  = gnt_any[c];
            rsp_rob_id[c] = bank_rsp_rob_id[gnt_bank[c]];
            rsp_data[c]   = bank_rsp_data[gnt_bank[c]];
            if (gnt_any[c])
                bank_rsp_ready[gnt_bank[c]] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int c = 0; c < NUM_CH; c++)
                last_q[c] <= bank_id_t'(NUM_BANK - 1);
        end else begin
            for (int c = 0; c < NUM_CH; c++) begin
                if (gnt_any[c])    // slot is reserved, so a grant always lands
                    last_q[c] <= gnt_bank[c];
            end
        end
    end

endmodule

// ==== rtl/mpc_xbar.sv ====
`timescale 1ns/1ps
`include "mpc_xbar_params.svh"

module mpc_xbar
    import mpc_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic [`MPC_NUM_CH-1:0]   ch_req_valid,
    output logic [`MPC_NUM_CH-1:0]   ch_req_ready,
    input  logic [`MPC_NUM_CH-1:0]   ch_req_write,
    input  addr_t                    ch_req_addr       [`MPC_NUM_CH],
    input  data_t                    ch_req_wdata      [`MPC_NUM_CH],

    output logic [`MPC_NUM_BANK-1:0] bank_req_valid,
    input  logic [`MPC_NUM_BANK-1:0] bank_req_ready,
    output logic [`MPC_NUM_BANK-1:0] bank_req_write,
    output addr_t                    bank_req_addr     [`MPC_NUM_BANK],
    output data_t                    bank_req_wdata    [`MPC_NUM_BANK],
    output ch_id_t                   bank_req_ch_id    [`MPC_NUM_BANK],
    output rob_id_t                  bank_req_rob_id   [`MPC_NUM_BANK],
    output wbuf_id_t                 bank_req_wbuf_id  [`MPC_NUM_BANK],

    input  logic [`MPC_NUM_BANK-1:0] bank_wbuf_free_valid,
    input  wbuf_id_t                 bank_wbuf_free_id [`MPC_NUM_BANK],

    input  logic [`MPC_NUM_BANK-1:0] bank_rsp_valid,
    output logic [`MPC_NUM_BANK-1:0] bank_rsp_ready,
    input  data_t                    bank_rsp_data     [`MPC_NUM_BANK],
    input  ch_id_t                   bank_rsp_ch_id    [`MPC_NUM_BANK],
    input  rob_id_t                  bank_rsp_rob_id   [`MPC_NUM_BANK],

    output logic [`MPC_NUM_CH-1:0]   ch_rsp_valid,
    input  logic [`MPC_NUM_CH-1:0]   ch_rsp_ready,
    output data_t                    ch_rsp_data       [`MPC_NUM_CH]
);

    ch_req_if   ch_req_bus   [`MPC_NUM_CH] ();
    bank_req_if bank_req_bus [`MPC_NUM_BANK] ();

    logic [`MPC_NUM_CH-1:0] rsp_valid;    // rsp_xbar -> chan_rob, no back-pressure
    rob_id_t                rsp_rob_id [`MPC_NUM_CH];
    data_t                  rsp_data   [`MPC_NUM_CH];

    // **************************************************
    // per-channel reorder buffers
    // **************************************************
    for (genvar c = 0; c < `MPC_NUM_CH; c++) begin : g_ch
        chan_rob u_chan_rob (
            .clk          (clk),
            .rst_n        (rst_n),
            .req_valid    (ch_req_valid[c]),
            .req_write    (ch_req_write[c]),
            .req_addr     (ch_req_addr[c]),
            .req_wdata    (ch_req_wdata[c]),
            .req_ready    (ch_req_ready[c]),
            .ch_req       (ch_req_bus[c]),
            .rsp_valid    (rsp_valid[c]),
            .rsp_rob_id   (rsp_rob_id[c]),
            .rsp_data     (rsp_data[c]),
            .ch_rsp_valid (ch_rsp_valid[c]),
            .ch_rsp_data  (ch_rsp_data[c]),
            .ch_rsp_ready (ch_rsp_ready[c])
        );
    end

    req_xbar u_req_xbar (
        .clk      (clk),
        .rst_n    (rst_n),
        .ch_req   (ch_req_bus),
        .bank_req (bank_req_bus)
    );

    // **************************************************
    // write-buffer id gate in front of every bank
    // **************************************************
    for (genvar b = 0; b < `MPC_NUM_BANK; b++) begin : g_bank
        wbuf_id_alloc u_wbuf_id_alloc (
            .clk              (clk),
            .rst_n            (rst_n),
            .req_in           (bank_req_bus[b]),
            .bank_req_valid   (bank_req_valid[b]),
            .bank_req_write   (bank_req_write[b]),
            .bank_req_addr    (bank_req_addr[b]),
            .bank_req_wdata   (bank_req_wdata[b]),
            .bank_req_ch_id   (bank_req_ch_id[b]),
            .bank_req_rob_id  (bank_req_rob_id[b]),
            .bank_req_wbuf_id (bank_req_wbuf_id[b]),
            .bank_req_ready   (bank_req_ready[b]),
            .free_valid       (bank_wbuf_free_valid[b]),
            .free_id          (bank_wbuf_free_id[b])
        );
    end

    rsp_xbar u_rsp_xbar (
        .clk             (clk),
        .rst_n           (rst_n),
        .bank_rsp_valid  (bank_rsp_valid),
        .bank_rsp_data   (bank_rsp_data),
        .bank_rsp_ch_id  (bank_rsp_ch_id),
        .bank_rsp_rob_id (bank_rsp_rob_id),
        .bank_rsp_ready  (bank_rsp_ready),
        .rsp_valid       (rsp_valid),
        .rsp_rob_id      (rsp_rob_id),
        .rsp_data        (rsp_data)
    );

endmodule

// ==== bench/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD = 4.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

endmodule

// ==== bench/tb_bank_model.sv ====
`timescale 1ns/1ps
`include "mpc_xbar_params.svh"

module tb_bank_model
    import mpc_pkg::*;
#(
    parameter logic [31:0] SEED = 32'h1
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`MPC_NUM_BANK-1:0] req_valid,
    output logic [`MPC_NUM_BANK-1:0] req_ready,
    input  logic [`MPC_NUM_BANK-1:0] req_write,
    input  addr_t                    req_addr    [`MPC_NUM_BANK],
    input  ch_id_t                   req_ch_id   [`MPC_NUM_BANK],
    input  rob_id_t                  req_rob_id  [`MPC_NUM_BANK],
    input  wbuf_id_t                 req_wbuf_id [`MPC_NUM_BANK],
    output logic [`MPC_NUM_BANK-1:0] free_valid,
    output wbuf_id_t                 free_id     [`MPC_NUM_BANK],
    output logic [`MPC_NUM_BANK-1:0] rsp_valid,
    input  logic [`MPC_NUM_BANK-1:0] rsp_ready,
    output data_t                    rsp_data    [`MPC_NUM_BANK],
    output ch_id_t                   rsp_ch_id   [`MPC_NUM_BANK],
    output rob_id_t                  rsp_rob_id  [`MPC_NUM_BANK],
    output logic                     idle
);

    localparam int NB = `MPC_NUM_BANK;

    logic [31:0] rand_q = SEED;
    int          cyc = 0;
    logic [67:0] rsp_q  [NB][$];    // {due cycle, ch_id, rob_id, addr}
    logic [33:0] free_q [NB][$];    // {due cycle, wbuf id}

    function automatic logic [31:0] next_rand();
        rand_q = rand_q * 32'd1664525 + 32'd1013904223;
        return rand_q >> 8;
    endfunction

    initial begin
        req_ready  = '0;
        free_valid = '0;
        rsp_valid  = '0;
        idle       = 1'b1;
        for (int b = 0; b < NB; b++) begin
            free_id[b]    = '0;
            rsp_data[b]   = '0;
            rsp_ch_id[b]  = '0;
            rsp_rob_id[b] = '0;
        end
    end

    // **************************************************
    // take requests and retire accepted responses
    // **************************************************
    always @(posedge clk) begin
        logic [31:0] r;
        if (!rst_n) begin
            cyc = 0;
            for (int b = 0; b < NB; b++) begin
                rsp_q[b].delete();
                free_q[b].delete();
            end
        end else begin
            cyc = cyc + 1;
            for (int b = 0; b < NB; b++) begin
                if (rsp_valid[b] && rsp_ready[b])
                    void'(rsp_q[b].pop_front());
                if (req_valid[b] && req_ready[b]) begin
                    r = next_rand();
                    rsp_q[b].push_back({32'(cyc) + 32'd2 + 32'(r[3:0]),
                                        req_ch_id[b], req_rob_id[b], req_addr[b]});
                    if (req_write[b])
                        free_q[b].push_back({32'(cyc) + 32'd1 + 32'(r[7:5]), req_wbuf_id[b]});
                end
            end
        end
    end

    always @(negedge clk) begin
        logic [31:0] r;
        logic [67:0] ent;
        logic [33:0] fr;
        idle = 1'b1;
        for (int b = 0; b < NB; b++) begin
            r             = next_rand();
            req_ready[b]  = rst_n && (r[1:0] != 2'b00);    // busy one cycle in four
            rsp_valid[b]  = 1'b0;
            free_valid[b] = 1'b0;
            if (rsp_q[b].size() != 0) begin
                ent = rsp_q[b][0];
                if (ent[67:36] <= 32'(cyc)) begin
                    rsp_valid[b]  = 1'b1;
                    rsp_ch_id[b]  = ent[35:34];
                    rsp_rob_id[b] = ent[33:32];
                    rsp_data[b]   = {4{ent[31:0]}};
                end
            end
            if (free_q[b].size() != 0) begin
                fr = free_q[b][0];
                if (fr[33:2] <= 32'(cyc)) begin
                    free_valid[b] = 1'b1;    // one-cycle strobe
                    free_id[b]    = fr[1:0];
                    void'(free_q[b].pop_front());
                end
            end
            if (rsp_q[b].size() != 0 || free_q[b].size() != 0)
                idle = 1'b0;
        end
    end

endmodule

// ==== bench/tb_mpc_xbar.sv ====
`timescale 1ns/1ps
`include "mpc_xbar_params.svh"

module tb_mpc_xbar
    import mpc_pkg::*;
;

    localparam int NCH        = `MPC_NUM_CH;
    localparam int NB         = `MPC_NUM_BANK;
    localparam int ROB        = `MPC_ROB_DEPTH;
    localparam int RAND_REQS  = 40;
    localparam int FAIR_REQS  = 20;
    localparam int STALL_REQS = 8;
    localparam int TOTAL_REQS = NCH * (RAND_REQS + FAIR_REQS + STALL_REQS);
    localparam logic [31:0] SEED = 32'he0ba_42f1;

    localparam int RSP_RANDOM = 0;
    localparam int RSP_OPEN   = 1;
    localparam int RSP_HOLD   = 2;

    logic clk;
    logic rst_n;
    logic [NCH-1:0] ch_req_valid, ch_req_ready, ch_req_write;
    addr_t          ch_req_addr  [NCH];
    data_t          ch_req_wdata [NCH];
    logic [NB-1:0]  bank_req_valid, bank_req_ready, bank_req_write;
    addr_t          bank_req_addr    [NB];
    data_t          bank_req_wdata   [NB];
    ch_id_t         bank_req_ch_id   [NB];
    rob_id_t        bank_req_rob_id  [NB];
    wbuf_id_t       bank_req_wbuf_id [NB];
    logic [NB-1:0]  bank_wbuf_free_valid;
    wbuf_id_t       bank_wbuf_free_id [NB];
    logic [NB-1:0]  bank_rsp_valid, bank_rsp_ready;
    data_t          bank_rsp_data   [NB];
    ch_id_t         bank_rsp_ch_id  [NB];
    rob_id_t        bank_rsp_rob_id [NB];
    logic [NCH-1:0] ch_rsp_valid, ch_rsp_ready;
    data_t          ch_rsp_data [NCH];
    logic           banks_idle;

    logic [31:0] rand_q = SEED;
    int          rsp_mode;
    logic        seen_req;
    addr_t       ref_q [NCH][$];    // issued addresses per channel in issue order
    addr_t       exp_head [NCH];
    int          outst [NCH];
    int          issued [NCH];    // accepted requests per channel
    int          wait_cnt [NCH];
    logic [`MPC_WBUF_DEPTH-1:0] wbuf_busy [NB];
    int          wr_out [NB];

    tb_clk_gen #(.PERIOD(4.0)) i_clk_gen (.clk(clk));

    mpc_xbar i_mpc_xbar (.*);

    tb_bank_model #(.SEED(SEED)) i_bank_model (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (bank_req_valid),
        .req_ready   (bank_req_ready),
        .req_write   (bank_req_write),
        .req_addr    (bank_req_addr),
        .req_ch_id   (bank_req_ch_id),
        .req_rob_id  (bank_req_rob_id),
        .req_wbuf_id (bank_req_wbuf_id),
        .free_valid  (bank_wbuf_free_valid),
        .free_id     (bank_wbuf_free_id),
        .rsp_valid   (bank_rsp_valid),
        .rsp_ready   (bank_rsp_ready),
        .rsp_data    (bank_rsp_data),
        .rsp_ch_id   (bank_rsp_ch_id),
        .rsp_rob_id  (bank_rsp_rob_id),
        .idle        (banks_idle)
    );

    function automatic logic [31:0] next_rand();
        rand_q = rand_q * 32'd1664525 + 32'd1013904223;
        return rand_q >> 8;
    endfunction

    task automatic report_value(input string name, input logic [127:0] got,
                                input logic [127:0] exp);
        $display("ERR %s got=0x%h exp=0x%h", name, got, exp);
        $display("Testbench failed");
        $fatal(1, "check on %s", name);
    endtask

    task automatic report_plain(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "%s", msg);
    endtask

    // **************************************************
    // reference model state sampled at the rising edge
    // **************************************************
    always @(posedge clk) begin
        logic [`MPC_WBUF_DEPTH-1:0] busy;
        int       cnt;
        bank_id_t bk;
        logic     elig;
        if (!rst_n) begin
            seen_req <= 1'b0;
            for (int c = 0; c < NCH; c++) begin
                ref_q[c].delete();
                outst[c]    <= 0;
                issued[c]   <= 0;
                exp_head[c] <= '0;
                wait_cnt[c] <= 0;
            end
            for (int b = 0; b < NB; b++) begin
                wbuf_busy[b] <= '0;
                wr_out[b]    <= 0;
            end
        end else begin
            if (ch_req_valid != '0)
                seen_req <= 1'b1;
            for (int c = 0; c < NCH; c++) begin
                bk   = ch_req_addr[c][`MPC_BANK_LSB +: 2];
                elig = ch_req_valid[c] && outst[c] < ROB;    // a full rob drops out of arbitration
                if (!elig || ch_req_ready[c])
                    wait_cnt[c] <= 0;
                else if (bank_req_valid[bk] && bank_req_ready[bk])
                    wait_cnt[c] <= wait_cnt[c] + 1;
                if (ch_req_valid[c] && ch_req_ready[c]) begin
                    ref_q[c].push_back(ch_req_addr[c]);
                    issued[c] <= issued[c] + 1;
                end
                if (ch_rsp_valid[c] && ch_rsp_ready[c] && ref_q[c].size() != 0)
                    void'(ref_q[c].pop_front());
                outst[c]    <= ref_q[c].size();
                exp_head[c] <= (ref_q[c].size() != 0) ? ref_q[c][0] : '0;
            end
            for (int b = 0; b < NB; b++) begin
                busy = wbuf_busy[b];
                cnt  = wr_out[b];
                if (bank_wbuf_free_valid[b]) begin
                    busy[bank_wbuf_free_id[b]] = 1'b0;
                    cnt = cnt - 1;
                end
                if (bank_req_valid[b] && bank_req_ready[b] && bank_req_write[b]) begin
                    busy[bank_req_wbuf_id[b]] = 1'b1;
                    cnt = cnt + 1;
                end
                wbuf_busy[b] <= busy;
                wr_out[b]    <= cnt;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        !seen_req && ch_req_valid == '0 |-> bank_req_valid == '0)
        else report_value("bank_req_valid", 128'($sampled(bank_req_valid)), 128'(0));

    assert property (@(posedge clk) disable iff (!rst_n)
        !seen_req && ch_req_valid == '0 |-> ch_rsp_valid == '0)
        else report_value("ch_rsp_valid", 128'($sampled(ch_rsp_valid)), 128'(0));

    for (genvar c = 0; c < NCH; c++) begin : g_ch_chk
        assert property (@(posedge clk) disable iff (!rst_n)
            ch_rsp_valid[c] && ch_rsp_ready[c] |->
                outst[c] != 0 && ch_rsp_data[c] == {4{exp_head[c]}})
            else report_value("ch_rsp_data", $sampled(ch_rsp_data[c]),
                              {4{$sampled(exp_head[c])}});
        assert property (@(posedge clk) disable iff (!rst_n)
            outst[c] >= ROB |-> !ch_req_ready[c])
            else report_value("ch_req_ready", 128'($sampled(ch_req_ready[c])), 128'(0));
        assert property (@(posedge clk) disable iff (!rst_n) wait_cnt[c] <= NCH - 1)
            else report_plain("a waiting channel saw too many grants to other channels");
    end

    for (genvar b = 0; b < NB; b++) begin : g_bank_chk
        assert property (@(posedge clk) disable iff (!rst_n)
            bank_req_valid[b] |-> bank_req_addr[b][`MPC_BANK_LSB +: 2] == bank_id_t'(b))
            else report_value("bank_req_addr", 128'($sampled(bank_req_addr[b])), 128'(b));
        assert property (@(posedge clk) disable iff (!rst_n)
            bank_req_valid[b] |-> ch_req_valid[bank_req_ch_id[b]] &&
                ch_req_addr[bank_req_ch_id[b]] == bank_req_addr[b] &&
                ch_req_wdata[bank_req_ch_id[b]] == bank_req_wdata[b] &&
                ch_req_write[bank_req_ch_id[b]] == bank_req_write[b])
            else report_value("bank_req_ch_id", 128'($sampled(bank_req_ch_id[b])), 128'(0));
        // reorder slots are handed out in issue order and wrap at the rob depth
        assert property (@(posedge clk) disable iff (!rst_n)
            bank_req_valid[b] && bank_req_ready[b] |->
                bank_req_rob_id[b] == rob_id_t'(issued[bank_req_ch_id[b]] % ROB))
            else report_value("bank_req_rob_id", 128'($sampled(bank_req_rob_id[b])),
                              128'($sampled(issued[bank_req_ch_id[b]]) % ROB));
        assert property (@(posedge clk) disable iff (!rst_n)
            bank_rsp_ready[b] |-> bank_rsp_valid[b])
            else report_value("bank_rsp_ready", 128'($sampled(bank_rsp_ready[b])), 128'(0));
        assert property (@(posedge clk) disable iff (!rst_n)
            bank_req_valid[b] && bank_req_ready[b] && bank_req_write[b] |->
                !wbuf_busy[b][bank_req_wbuf_id[b]])
            else report_value("bank_req_wbuf_id", 128'($sampled(bank_req_wbuf_id[b])),
                              128'($sampled(wbuf_busy[b])));
        assert property (@(posedge clk) disable iff (!rst_n) wr_out[b] <= `MPC_WBUF_DEPTH)
            else report_value("wr_out", 128'($sampled(wr_out[b])), 128'(`MPC_WBUF_DEPTH));
    end

    // **************************************************
    // stimulus driven on the falling edge
    // **************************************************
    always @(negedge clk) begin
        logic [31:0] r;
        r = next_rand();
        case (rsp_mode)
            RSP_OPEN: ch_rsp_ready = '1;
            RSP_HOLD: ch_rsp_ready = '0;
            default:  ch_rsp_ready = r[NCH-1:0];
        endcase
    end

    task automatic send_req(input int c, input addr_t addr, input logic wr);
        @(negedge clk);
        ch_req_valid[c] = 1'b1;
        ch_req_write[c] = wr;
        ch_req_addr[c]  = addr;
        ch_req_wdata[c] = {4{~addr}};
        @(posedge clk);
        while (!ch_req_ready[c])
            @(posedge clk);
    endtask

    task automatic run_channel(input int c, input int n, input logic one_bank);
        logic [31:0] r;
        addr_t       a;
        for (int i = 0; i < n; i++) begin
            r = next_rand();
            a = r;
            if (one_bank)
                a[`MPC_BANK_LSB +: 2] = 2'd2;
            send_req(c, a, r[9]);
        end
        @(negedge clk);
        ch_req_valid[c] = 1'b0;
    endtask

    task automatic run_phase(input int n, input logic one_bank);
        for (int c = 0; c < NCH; c++) begin
            fork
                automatic int cc = c;
                run_channel(cc, n, one_bank);
            join_none
        end
        wait fork;
    endtask

    initial begin
        rst_n        = 1'b0;
        rsp_mode     = RSP_RANDOM;
        ch_req_valid = '0;
        ch_req_write = '0;
        ch_rsp_ready = '0;
        for (int c = 0; c < NCH; c++) begin
            ch_req_addr[c]  = '0;
            ch_req_wdata[c] = '0;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        repeat (4) @(posedge clk);

        run_phase(RAND_REQS, 1'b0);
        rsp_mode = RSP_OPEN;
        run_phase(FAIR_REQS, 1'b1);    // all channels fight for bank 2

        rsp_mode = RSP_HOLD;
        fork
            begin
                while (!(outst[0] >= ROB && outst[1] >= ROB && outst[2] >= ROB))
                    @(posedge clk);
                repeat (20) @(posedge clk);
                rsp_mode = RSP_OPEN;
            end
        join_none
        run_phase(STALL_REQS, 1'b0);    // also waits for the release above

        while (!(banks_idle && outst[0] == 0 && outst[1] == 0 && outst[2] == 0))
            @(posedge clk);
        repeat (4) @(posedge clk);
        if (wr_out[0] == 0 && wr_out[1] == 0 && wr_out[2] == 0 && wr_out[3] == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            report_plain("write-buffer ids still outstanding after the banks went idle");
        end
    end

    initial begin
        repeat (TOTAL_REQS * 40) @(posedge clk);
        report_plain("watchdog expired before all traffic completed");
    end

endmodule

// ==== mpc_xbar.f ====
+incdir+rtl
rtl/mpc_pkg.sv
rtl/mpc_ifs.sv
rtl/req_xbar.sv
rtl/wbuf_id_alloc.sv
rtl/chan_rob.sv
rtl/rsp_xbar.sv
rtl/mpc_xbar.sv
bench/tb_clk_gen.sv
bench/tb_bank_model.sv
bench/tb_mpc_xbar.sv

// ==== Makefile ====
TOP  := tb_mpc_xbar
BIN  := obj_dir/V$(TOP)
SRCS := $(shell grep '\.sv$$' mpc_xbar.f) rtl/mpc_xbar_params.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) mpc_xbar.f
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f mpc_xbar.f

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "^Testbench passed$$"

clean:
	rm -rf obj_dir
